// File: imuldiv_pkg.sv
// --------------------
// shared types and codes for the iterative multiply/divide unit
// --------------------

package imuldiv_pkg;

  // operand and half-result width
  typedef logic [31:0] word_t;

  // full response result
  typedef logic [63:0] dword_t;

  // function code on the request port
  typedef logic [1:0] fn_t;

  // unsigned 64-bit product
  localparam fn_t FN_MUL  = 2'd0;
  // unsigned divide
  localparam fn_t FN_DIVU = 2'd1;
  // signed divide
  localparam fn_t FN_DIV  = 2'd2;

  // which unit produced a response
  typedef logic unit_t;

  localparam unit_t UNIT_MUL = 1'b0;
  localparam unit_t UNIT_DIV = 1'b1;

  // iteration counter, counts down from 31 to 0
  typedef logic [4:0] count_t;

  // loaded at start so that 32 iterations run
  localparam count_t ITER_LAST = 5'd31;

  // three-state unit FSM, shared by multiplier and divider control
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_CALC,
    DIV_DONE
  } div_state_t;

endpackage

// File: int_mul_iterative.sv
// --------------------
// iterative shift-add multiplier
// 32 iterations give the full unsigned 64-bit product
// --------------------

`timescale 1ns/1ns

module int_mul_iterative import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   start,
  input  word_t  a,
  input  word_t  b,
  input  logic   grant,
  output logic   busy,
  output logic   done,
  output dword_t result
);

  div_state_t state_q;

  // product accumulator
  dword_t acc_q;
  // multiplicand, shifted left every iteration
  dword_t mcand_q;
  // multiplier, shifted right so bit 0 is the current bit
  word_t  mplier_q;
  count_t cnt_q;

  // --------------------
  // FSM
  // --------------------

  // a start while not idle is a requester error and is dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= DIV_IDLE;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (start) begin
            state_q <= DIV_CALC;
          end
        end
        DIV_CALC: begin
          // last iteration runs while the counter reads zero
          if (cnt_q == '0) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          // leave in the grant cycle
          if (grant) begin
            state_q <= DIV_IDLE;
          end
        end
        default: begin
          state_q <= DIV_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (state_q == DIV_IDLE && start) begin
      acc_q    <= '0;
      mcand_q  <= {32'b0, a};
      mplier_q <= b;
      cnt_q    <= ITER_LAST;
    end else if (state_q == DIV_CALC) begin
      // add the shifted multiplicand when this multiplier bit is set
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
      cnt_q    <= cnt_q - 5'd1;
    end
  end

  assign busy   = (state_q != DIV_IDLE);
  assign done   = (state_q == DIV_DONE);
  // accumulator is frozen in done, so the product stays steady until granted
  assign result = acc_q;

endmodule

// File: int_div_dpath.sv
// --------------------
// restoring divider datapath
// magnitudes, shift-subtract register, counter and sign fix-up
// --------------------

`timescale 1ns/1ns

module int_div_dpath import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  a,
  input  word_t  b,
  input  logic   is_signed,
  input  logic   a_en,
  input  logic   b_en,
  input  logic   a_sel_calc,
  input  logic   sub_keep_sel,
  input  logic   cnt_load,
  input  logic   sign_en,
  input  logic   quot_neg,
  input  logic   rem_neg,
  output logic   sub_neg,
  output logic   cnt_zero,
  output dword_t result
);

  // remainder in [64:32], quotient bits shift in at [0]
  logic [64:0] rq_q;
  // divisor aligned against the remainder half
  logic [64:0] dvs_q;
  count_t      cnt_q;

  // latched result signs
  logic quot_sign_q;
  logic rem_sign_q;

  word_t a_mag;
  word_t b_mag;

  logic [64:0] rq_init;
  logic [64:0] rq_shift;
  logic [64:0] rq_diff;
  logic [64:0] rq_calc;

  word_t quot;
  word_t rem;

  // --------------------
  // operand magnitudes
  // --------------------

  // only signed divide works on absolute values
  assign a_mag = (is_signed && a[31]) ? (~a + 32'd1) : a;
  assign b_mag = (is_signed && b[31]) ? (~b + 32'd1) : b;

  assign rq_init = {33'b0, a_mag};

  // --------------------
  // shift and trial subtract
  // --------------------

  assign rq_shift = rq_q << 1;
  assign rq_diff  = rq_shift - dvs_q;
  // a borrow out of the subtract shows the divisor did not fit
  assign sub_neg  = rq_diff[64];

  // keep the difference and set the quotient bit, or restore the shifted value
  assign rq_calc = sub_keep_sel ? {rq_diff[64:1], 1'b1} : {rq_shift[64:1], 1'b0};

  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_q <= a_sel_calc ? rq_calc : rq_init;
    end
    if (b_en) begin
      dvs_q <= {1'b0, b_mag, 32'b0};
    end
    if (sign_en) begin
      // quotient negative on differing signs, remainder follows a
      quot_sign_q <= a[31] ^ b[31];
      rem_sign_q  <= a[31];
    end
  end

  // iteration counter
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (cnt_load) begin
      cnt_q <= ITER_LAST;
    end else if (a_en) begin
      cnt_q <= cnt_q - 5'd1;
    end
  end

  assign cnt_zero = (cnt_q == '0);

  // --------------------
  // sign fix-up
  // --------------------

  assign quot = rq_q[31:0];
  assign rem  = rq_q[63:32];

  // selects from control are only high for a signed op in done
  assign result[31:0]  = (quot_neg && quot_sign_q) ? (~quot + 32'd1) : quot;
  assign result[63:32] = (rem_neg && rem_sign_q) ? (~rem + 32'd1) : rem;

endmodule

// File: int_div_ctrl.sv
// --------------------
// divider control FSM
// idle, calc and done, driving the datapath enables and selects
// --------------------

`timescale 1ns/1ns

module int_div_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  fn_t  fn,
  input  logic sub_neg,
  input  logic cnt_zero,
  input  logic grant,
  output logic busy,
  output logic done,
  output logic is_signed,
  output logic a_en,
  output logic b_en,
  output logic a_sel_calc,
  output logic sub_keep_sel,
  output logic cnt_load,
  output logic sign_en,
  output logic quot_neg,
  output logic rem_neg
);

  div_state_t state_q;
  // signedness of the op in flight
  logic       signed_q;
  logic       accept;

  // a start outside idle is dropped
  assign accept = (state_q == DIV_IDLE) && start;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= DIV_IDLE;
      signed_q <= 1'b0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (accept) begin
            state_q  <= DIV_CALC;
            signed_q <= (fn == FN_DIV);
          end
        end
        DIV_CALC: begin
          if (cnt_zero) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (grant) begin
            state_q <= DIV_IDLE;
          end
        end
        default: begin
          state_q <= DIV_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // control outputs
  // --------------------

  always_comb begin
    a_en         = 1'b0;
    b_en         = 1'b0;
    a_sel_calc   = 1'b0;
    sub_keep_sel = 1'b0;
    cnt_load     = 1'b0;
    sign_en      = 1'b0;
    quot_neg     = 1'b0;
    rem_neg      = 1'b0;
    // in idle the magnitudes are taken straight from the incoming code
    is_signed    = signed_q;
    case (state_q)
      DIV_IDLE: begin
        is_signed = (fn == FN_DIV);
        a_en      = accept;
        b_en      = accept;
        cnt_load  = accept;
        sign_en   = accept;
      end
      DIV_CALC: begin
        a_en         = 1'b1;
        a_sel_calc   = 1'b1;
        // no borrow means the divisor fit
        sub_keep_sel = ~sub_neg;
      end
      DIV_DONE: begin
        quot_neg = signed_q;
        rem_neg  = signed_q;
      end
      default: begin
        a_en = 1'b0;
      end
    endcase
  end

  assign busy = (state_q != DIV_IDLE);
  assign done = (state_q == DIV_DONE);

endmodule

// File: result_arbiter.sv
// --------------------
// fixed-priority arbiter for the shared response bus
// multiplier first, response registered as a one-cycle strobe
// --------------------

`timescale 1ns/1ns

module result_arbiter import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   mul_done,
  input  logic   div_done,
  input  dword_t mul_result,
  input  dword_t div_result,
  output logic   mul_grant,
  output logic   div_grant,
  output logic   resp_val,
  output unit_t  resp_unit,
  output dword_t resp_result
);

  // grant in the first cycle done is seen, units drop done on grant
  assign mul_grant = mul_done;
  // divider waits while the multiplier is done
  assign div_grant = div_done && !mul_done;

  // --------------------
  // response register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else begin
      resp_val <= mul_grant || div_grant;
    end
  end

  // payload only moves on a grant
  always_ff @(posedge clk) begin
    if (mul_grant) begin
      resp_unit   <= UNIT_MUL;
      resp_result <= mul_result;
    end else if (div_grant) begin
      resp_unit   <= UNIT_DIV;
      resp_result <= div_result;
    end
  end

endmodule

// File: imuldiv_top.sv
// --------------------
// multiply/divide unit top
// request decode, the two units and the shared response bus
// --------------------

`timescale 1ns/1ns

module imuldiv_top import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   req_val,
  input  fn_t    req_fn,
  input  word_t  req_a,
  input  word_t  req_b,
  output logic   mul_busy,
  output logic   div_busy,
  output logic   resp_val,
  output unit_t  resp_unit,
  output dword_t resp_result
);

  logic   mul_start;
  logic   div_start;
  logic   mul_done;
  logic   div_done;
  logic   mul_grant;
  logic   div_grant;
  dword_t mul_result;
  dword_t div_result;

  // divider control to datapath
  logic is_signed;
  logic a_en;
  logic b_en;
  logic a_sel_calc;
  logic sub_keep_sel;
  logic cnt_load;
  logic sign_en;
  logic quot_neg;
  logic rem_neg;
  logic sub_neg;
  logic cnt_zero;

  // --------------------
  // request decode
  // --------------------

  // unused code 3 starts neither unit
  assign mul_start = req_val && (req_fn == FN_MUL);
  assign div_start = req_val && ((req_fn == FN_DIVU) || (req_fn == FN_DIV));

  int_mul_iterative mul_i (
    .clk    (clk),
    .reset  (reset),
    .start  (mul_start),
    .a      (req_a),
    .b      (req_b),
    .grant  (mul_grant),
    .busy   (mul_busy),
    .done   (mul_done),
    .result (mul_result)
  );

  int_div_ctrl div_ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .start        (div_start),
    .fn           (req_fn),
    .sub_neg      (sub_neg),
    .cnt_zero     (cnt_zero),
    .grant        (div_grant),
    .busy         (div_busy),
    .done         (div_done),
    .is_signed    (is_signed),
    .a_en         (a_en),
    .b_en         (b_en),
    .a_sel_calc   (a_sel_calc),
    .sub_keep_sel (sub_keep_sel),
    .cnt_load     (cnt_load),
    .sign_en      (sign_en),
    .quot_neg     (quot_neg),
    .rem_neg      (rem_neg)
  );

  int_div_dpath div_dpath_i (
    .clk          (clk),
    .reset        (reset),
    .a            (req_a),
    .b            (req_b),
    .is_signed    (is_signed),
    .a_en         (a_en),
    .b_en         (b_en),
    .a_sel_calc   (a_sel_calc),
    .sub_keep_sel (sub_keep_sel),
    .cnt_load     (cnt_load),
    .sign_en      (sign_en),
    .quot_neg     (quot_neg),
    .rem_neg      (rem_neg),
    .sub_neg      (sub_neg),
    .cnt_zero     (cnt_zero),
    .result       (div_result)
  );

  // --------------------
  // response bus
  // --------------------

  result_arbiter arb_i (
    .clk         (clk),
    .reset       (reset),
    .mul_done    (mul_done),
    .div_done    (div_done),
    .mul_result  (mul_result),
    .div_result  (div_result),
    .mul_grant   (mul_grant),
    .div_grant   (div_grant),
    .resp_val    (resp_val),
    .resp_unit   (resp_unit),
    .resp_result (resp_result)
  );

endmodule

// File: tb_imuldiv.sv
// --------------------
// testbench for the multiply/divide unit
// random requests checked against a reference model and scoreboard
// --------------------

`timescale 1ns/1ns

module tb_imuldiv import imuldiv_pkg::*; ();

  localparam int TIMEOUT = 200;

  logic   clk;
  logic   reset;
  logic   req_val;
  fn_t    req_fn;
  word_t  req_a;
  word_t  req_b;
  logic   mul_busy;
  logic   div_busy;
  logic   resp_val;
  unit_t  resp_unit;
  dword_t resp_result;

  int errors = 0;
  int checks = 0;
  int test_errs = 0;
  int cyc = 0;

  // scoreboard, one expected entry per unit
  dword_t exp_mul;
  dword_t exp_div;
  logic   mul_pend;
  logic   div_pend;
  int     mul_issue_cyc;
  int     div_issue_cyc;

  word_t corners [4];

  imuldiv_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .mul_busy    (mul_busy),
    .div_busy    (div_busy),
    .resp_val    (resp_val),
    .resp_unit   (resp_unit),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // cycle stamp for ordering checks
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // --------------------
  // reference model
  // --------------------

  function automatic dword_t mul_model(word_t a, word_t b);
    dword_t wide_a;
    dword_t wide_b;
    wide_a = {32'b0, a};
    wide_b = {32'b0, b};
    return wide_a * wide_b;
  endfunction

  // remainder in the upper half, quotient in the lower half
  function automatic dword_t div_model(fn_t fn, word_t a, word_t b);
    logic  sgn;
    word_t a_mag;
    word_t b_mag;
    word_t q;
    word_t r;
    sgn   = (fn == FN_DIV);
    a_mag = (sgn && a[31]) ? (32'd0 - a) : a;
    b_mag = (sgn && b[31]) ? (32'd0 - b) : b;
    // divide by zero: all ones quotient, dividend as remainder
    if (b_mag == 32'd0) begin
      q = '1;
      r = a_mag;
    end else begin
      q = a_mag / b_mag;
      r = a_mag % b_mag;
    end
    if (sgn && (a[31] != b[31])) begin
      q = 32'd0 - q;
    end
    // remainder follows the dividend
    if (sgn && a[31]) begin
      r = 32'd0 - r;
    end
    return {r, q};
  endfunction

  // --------------------
  // checks and reporting
  // --------------------

  task automatic check_value(input string name, input dword_t got, input dword_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %s, %0d errors", name, (errors == test_errs) ? "ok" : "bad",
             errors - test_errs);
    test_errs = errors;
  endtask

  // --------------------
  // request and response
  // --------------------

  // waits for the target unit to be free, then strobes one request
  task automatic send_req(input fn_t fn, input word_t a, input word_t b);
    int   i;
    logic free;
    free = 1'b0;
    for (i = 0; i < TIMEOUT && !free; i++) begin
      @(negedge clk);
      free = (fn == FN_MUL) ? !mul_busy : !div_busy;
    end
    if (!free) begin
      note_failure("target unit stayed busy, request not sent");
    end else begin
      @(posedge clk);
      req_val <= 1'b1;
      req_fn  <= fn;
      req_a   <= a;
      req_b   <= b;
      if (fn == FN_MUL) begin
        exp_mul       = mul_model(a, b);
        mul_pend      = 1'b1;
        mul_issue_cyc = cyc;
      end else begin
        exp_div       = div_model(fn, a, b);
        div_pend      = 1'b1;
        div_issue_cyc = cyc;
      end
      @(posedge clk);
      req_val <= 1'b0;
    end
  endtask

  // takes one response off the bus and scores it against its unit
  task automatic wait_resp();
    int   i;
    logic seen;
    seen = 1'b0;
    for (i = 0; i < TIMEOUT && !seen; i++) begin
      @(negedge clk);
      seen = resp_val;
    end
    if (!seen) begin
      note_failure("no response within the timeout");
      mul_pend = 1'b0;
      div_pend = 1'b0;
    end else if (resp_unit == UNIT_MUL) begin
      if (!mul_pend) begin
        note_failure("multiplier response with no multiply outstanding");
      end else begin
        check_value("resp_result", resp_result, exp_mul);
        mul_pend = 1'b0;
      end
    end else begin
      if (!div_pend) begin
        note_failure("divider response with no divide outstanding");
      end else begin
        // equal latency, so an earlier multiply must not come second
        if (mul_pend && (mul_issue_cyc <= div_issue_cyc)) begin
          note_failure("divider response came before an earlier multiply");
        end
        check_value("resp_result", resp_result, exp_div);
        div_pend = 1'b0;
      end
    end
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    int    seed_ret;
    word_t a;
    word_t b;
    fn_t   fn;
    seed_ret   = $urandom(32'h3ab8c15f);
    reset      = 1'b1;
    req_val    = 1'b0;
    req_fn     = FN_MUL;
    req_a      = '0;
    req_b      = '0;
    mul_pend   = 1'b0;
    div_pend   = 1'b0;
    corners[0] = 32'h0000_0000;
    corners[1] = 32'h0000_0001;
    corners[2] = 32'hffff_ffff;
    corners[3] = 32'h8000_0000;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // idle after reset
    @(negedge clk);
    check_value("mul_busy", {63'b0, mul_busy}, 64'd0);
    check_value("div_busy", {63'b0, div_busy}, 64'd0);
    check_value("resp_val", {63'b0, resp_val}, 64'd0);
    finish_test("reset state");

    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        send_req(FN_MUL, corners[i], corners[j]);
        wait_resp();
      end
    end
    for (int n = 0; n < 12; n++) begin
      send_req(FN_MUL, $urandom, $urandom);
      wait_resp();
    end
    finish_test("unsigned multiply");

    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        send_req(FN_DIVU, corners[i], corners[j]);
        wait_resp();
      end
    end
    for (int n = 0; n < 12; n++) begin
      a = $urandom;
      // mix of zero, small and full-width divisors
      b = ($urandom % 4 == 0) ? 32'd0 : ($urandom >> ($urandom % 32));
      send_req(FN_DIVU, a, b);
      wait_resp();
    end
    finish_test("unsigned divide");

    send_req(FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    wait_resp();
    send_req(FN_DIV, 32'hffff_fff9, 32'd2);
    wait_resp();
    send_req(FN_DIV, 32'd7, 32'hffff_fffe);
    wait_resp();
    send_req(FN_DIV, 32'hffff_fff9, 32'hffff_fffe);
    wait_resp();
    send_req(FN_DIV, 32'hffff_fffb, 32'd0);
    wait_resp();
    send_req(FN_DIV, 32'd5, 32'd0);
    wait_resp();
    for (int n = 0; n < 12; n++) begin
      a = $urandom;
      b = ($urandom % 4 == 0) ? 32'd0 : ($urandom >> ($urandom % 32));
      // random divisor sign
      if ($urandom % 2 == 1) begin
        b = 32'd0 - b;
      end
      send_req(FN_DIV, a, b);
      wait_resp();
    end
    finish_test("signed divide");

    // both units in flight, random order and gap
    for (int n = 0; n < 8; n++) begin
      fn = ($urandom % 2 == 1) ? FN_DIV : FN_DIVU;
      if ($urandom % 2 == 1) begin
        send_req(FN_MUL, $urandom, $urandom);
        repeat ($urandom % 4) @(posedge clk);
        send_req(fn, $urandom, $urandom >> ($urandom % 32));
      end else begin
        send_req(fn, $urandom, $urandom >> ($urandom % 32));
        repeat ($urandom % 4) @(posedge clk);
        send_req(FN_MUL, $urandom, $urandom);
      end
      wait_resp();
      wait_resp();
    end
    finish_test("concurrent units");

    send_req(FN_MUL, $urandom, $urandom);
    @(negedge clk);
    check_value("mul_busy", {63'b0, mul_busy}, 64'd1);
    wait_resp();
    check_value("mul_busy", {63'b0, mul_busy}, 64'd0);
    send_req(FN_DIV, $urandom, $urandom >> 8);
    @(negedge clk);
    check_value("div_busy", {63'b0, div_busy}, 64'd1);
    wait_resp();
    check_value("div_busy", {63'b0, div_busy}, 64'd0);
    finish_test("busy flags");

    $display("all tests done, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: all.f
imuldiv_pkg.sv
int_mul_iterative.sv
int_div_dpath.sv
int_div_ctrl.sv
result_arbiter.sv
imuldiv_top.sv
tb_imuldiv.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and decide pass or fail from the simulation log
verilator --binary --timing --top-module tb_imuldiv -f all.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" ||
{ echo "FAIL"; exit 1; }
